// File: pong_pkg.sv
// shared types for the pong design
// coordinate, colour channel and score vectors, game states, fixed colours

package pong_pkg;

	localparam int CORDW = 10;	// covers 525 total columns

	typedef logic [CORDW-1:0] coord_t;	// screen and object positions
	typedef logic [4:0] chan_t;	// one 5-bit colour channel
	typedef logic [3:0] score_t;	// one side's score

	typedef enum logic [2:0] {
		NEW_GAME,	// clear scores
		POSITION,	// place ball and paddles
		READY,	// wait for serve
		POINT,	// point scored and waiting for fire
		END_GAME,	// game won and waiting for fire
		PLAY	// ball in motion
	} game_state_t;

	// warm yellow ball
	localparam chan_t COL_BALL_R = 5'h1f;
	localparam chan_t COL_BALL_G = 5'h1c;
	localparam chan_t COL_BALL_B = 5'h00;

	// white paddles and centre line
	localparam chan_t COL_PAD_R = 5'h1f;
	localparam chan_t COL_PAD_G = 5'h1f;
	localparam chan_t COL_PAD_B = 5'h1f;

	// deep blue background
	localparam chan_t COL_BG_R = 5'h02;
	localparam chan_t COL_BG_G = 5'h06;
	localparam chan_t COL_BG_B = 5'h1f;

endpackage

// File: display_timing.sv
// display timing generator
// pixel counters, active-low syncs, data enable and frame-start pulse

module display_timing #(
	parameter int H_RES = 480,	// active columns
	parameter int V_RES = 272,	// active lines
	parameter int H_FP = 2,	// horizontal front porch
	parameter int H_SYNC = 41,	// horizontal sync width
	parameter int H_BP = 2,	// horizontal back porch
	parameter int V_FP = 2,	// vertical front porch
	parameter int V_SYNC = 10,	// vertical sync width
	parameter int V_BP = 2	// vertical back porch
) (
	input  logic clk_pix,
	input  logic rst,
	output pong_pkg::coord_t sx,	// current column
	output pong_pkg::coord_t sy,	// current line
	output logic hsync,	// active low
	output logic vsync,	// active low
	output logic de,	// active pixel
	output logic frame	// first pixel of vertical blanking
);

	localparam pong_pkg::coord_t H_LAST = pong_pkg::coord_t'(H_RES + H_FP + H_SYNC + H_BP - 1);
	localparam pong_pkg::coord_t V_LAST = pong_pkg::coord_t'(V_RES + V_FP + V_SYNC + V_BP - 1);
	localparam pong_pkg::coord_t HS_STA = pong_pkg::coord_t'(H_RES + H_FP);
	localparam pong_pkg::coord_t HS_END = pong_pkg::coord_t'(H_RES + H_FP + H_SYNC);
	localparam pong_pkg::coord_t VS_STA = pong_pkg::coord_t'(V_RES + V_FP);
	localparam pong_pkg::coord_t VS_END = pong_pkg::coord_t'(V_RES + V_FP + V_SYNC);
	localparam pong_pkg::coord_t H_ACT = pong_pkg::coord_t'(H_RES);
	localparam pong_pkg::coord_t V_ACT = pong_pkg::coord_t'(V_RES);

	pong_pkg::coord_t sx_next, sy_next;	// position on the next cycle

	always_comb begin
		if (sx == H_LAST) begin	// end of line
			sx_next = '0;
			sy_next = (sy == V_LAST) ? '0 : sy + 1'b1;
		end else begin
			sx_next = sx + 1'b1;
			sy_next = sy;
		end
	end

	// decode from the next position so syncs stay aligned with sx and sy
	always_ff @(posedge clk_pix) begin
		if (rst) begin
			sx <= '0;
			sy <= '0;
			hsync <= 1'b1;	// inactive
			vsync <= 1'b1;
			de <= 1'b1;	// pixel 0,0 is active
			frame <= 1'b0;
		end else begin
			sx <= sx_next;
			sy <= sy_next;
			hsync <= ~(sx_next >= HS_STA && sx_next < HS_END);
			vsync <= ~(sy_next >= VS_STA && sy_next < VS_END);
			de <= (sx_next < H_ACT) && (sy_next < V_ACT);
			frame <= (sx_next == '0) && (sy_next == V_ACT);	// game update point
		end
	end

endmodule

// File: button_debounce.sv
// button debouncer
// two-flop synchroniser, hold counter, stable level and press pulse

module button_debounce #(
	parameter int DEB_BITS = 16	// hold time is 2**DEB_BITS cycles
) (
	input  logic clk_pix,
	input  logic rst,
	input  logic in,	// raw button, active high
	output logic level,	// debounced level
	output logic press	// one cycle on a rising level
);

	logic sync_0, sync_1;	// synchroniser flops
	logic [DEB_BITS-1:0] cnt;	// hold counter

	always_ff @(posedge clk_pix) begin
		if (rst) begin
			sync_0 <= 1'b0;
			sync_1 <= 1'b0;
		end else begin
			sync_0 <= in;
			sync_1 <= sync_0;
		end
	end

	always_ff @(posedge clk_pix) begin
		if (rst) begin
			cnt <= '0;
			level <= 1'b0;
			press <= 1'b0;
		end else begin
			press <= 1'b0;
			if (sync_1 == level) begin
				cnt <= '0;	// input agrees, restart hold
			end else if (cnt == '1) begin
				// held for a full count
				level <= sync_1;
				press <= sync_1;	// only on a rising change
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// File: pong_game.sv
// game logic
// state machine, ball motion and bounce, player and computer paddles, scores

module pong_game #(
	parameter int H_RES = 480,
	parameter int V_RES = 272,
	parameter int BALL_SIZE = 8,	// ball side in pixels
	parameter int BALL_SPX = 2,	// pixels per frame
	parameter int BALL_SPY = 1,
	parameter int PAD_HEIGHT = 48,
	parameter int PAD_WIDTH = 10,
	parameter int PAD_OFFS = 32,	// paddle gap from screen edge
	parameter int PAD_SPY = 3,	// paddle pixels per frame
	parameter int WIN = 4	// score that ends the game
) (
	input  logic clk_pix,
	input  logic rst,
	input  logic frame,	// start of vertical blanking
	input  logic fire,	// press pulse
	input  logic up,	// level
	input  logic dn,	// level
	input  logic hit_l,	// ball pixel on left paddle
	input  logic hit_r,	// ball pixel on right paddle
	output pong_pkg::coord_t ball_x,
	output pong_pkg::coord_t ball_y,
	output pong_pkg::coord_t padl_y,
	output pong_pkg::coord_t padr_y,
	output pong_pkg::score_t score_l,
	output pong_pkg::score_t score_r
);

	localparam pong_pkg::coord_t PAD_MAX = pong_pkg::coord_t'(V_RES - PAD_HEIGHT);
	localparam pong_pkg::coord_t PAD_MID = pong_pkg::coord_t'((V_RES - PAD_HEIGHT) / 2);
	localparam pong_pkg::coord_t PAD_HALF = pong_pkg::coord_t'(PAD_HEIGHT / 2);
	localparam pong_pkg::coord_t BALL_HALF = pong_pkg::coord_t'(BALL_SIZE / 2);
	localparam pong_pkg::coord_t X_MAX = pong_pkg::coord_t'(H_RES - BALL_SIZE);
	localparam pong_pkg::coord_t Y_MAX = pong_pkg::coord_t'(V_RES - BALL_SIZE);
	localparam pong_pkg::coord_t SERVE_LX = pong_pkg::coord_t'(PAD_OFFS + PAD_WIDTH);
	localparam pong_pkg::coord_t SERVE_RX =
		pong_pkg::coord_t'(H_RES - PAD_OFFS - PAD_WIDTH - BALL_SIZE);
	localparam pong_pkg::coord_t SERVE_Y = pong_pkg::coord_t'((V_RES - BALL_SIZE) / 2);
	localparam pong_pkg::coord_t SPX = pong_pkg::coord_t'(BALL_SPX);
	localparam pong_pkg::coord_t SPY = pong_pkg::coord_t'(BALL_SPY);
	localparam pong_pkg::coord_t PSPY = pong_pkg::coord_t'(PAD_SPY);
	localparam pong_pkg::score_t WIN_SCORE = pong_pkg::score_t'(WIN);

	pong_pkg::game_state_t state, state_next;
	logic ball_dx, ball_dy;	// 0 means right and down
	logic coll_l, coll_r;	// ball reached an edge
	logic edge_l, edge_r;	// edge reached on this frame step

	// edge test for the next horizontal step
	always_comb begin
		edge_r = !ball_dx && (ball_x + SPX >= X_MAX);
		edge_l = ball_dx && (ball_x <= SPX);
	end

	always_comb begin
		case (state)
			pong_pkg::NEW_GAME: state_next = pong_pkg::POSITION;
			pong_pkg::POSITION: state_next = pong_pkg::READY;
			pong_pkg::READY: state_next = fire ? pong_pkg::PLAY : pong_pkg::READY;
			pong_pkg::POINT: state_next = fire ? pong_pkg::POSITION : pong_pkg::POINT;
			pong_pkg::END_GAME: state_next = fire ? pong_pkg::NEW_GAME : pong_pkg::END_GAME;
			pong_pkg::PLAY: begin
				if (coll_l || coll_r)
					state_next = (score_l == WIN_SCORE || score_r == WIN_SCORE) ?
						pong_pkg::END_GAME : pong_pkg::POINT;
				else
					state_next = pong_pkg::PLAY;
			end
			default: state_next = pong_pkg::NEW_GAME;
		endcase
	end

	always_ff @(posedge clk_pix) begin
		if (rst) state <= pong_pkg::NEW_GAME;
		else state <= state_next;
	end

	// scores and edge flags
	always_ff @(posedge clk_pix) begin
		if (rst || state == pong_pkg::NEW_GAME) begin
			score_l <= '0;
			score_r <= '0;
			coll_l <= 1'b0;
			coll_r <= 1'b0;	// left serves a new game
		end else if (state == pong_pkg::POSITION) begin
			coll_l <= 1'b0;	// serve side already taken
			coll_r <= 1'b0;
		end else if (state == pong_pkg::PLAY && frame) begin
			if (edge_r) begin
				score_l <= score_l + 1'b1;
				coll_r <= 1'b1;
			end else if (edge_l) begin
				score_r <= score_r + 1'b1;
				coll_l <= 1'b1;
			end
		end
	end

	// ball position and direction
	always_ff @(posedge clk_pix) begin
		if (rst) begin
			ball_x <= SERVE_LX;
			ball_y <= SERVE_Y;
			ball_dx <= 1'b0;
			ball_dy <= 1'b0;
		end else if (state == pong_pkg::POSITION) begin
			ball_y <= SERVE_Y;
			ball_dy <= 1'b0;
			if (coll_r) begin	// right side serves after a right edge
				ball_x <= SERVE_RX;
				ball_dx <= 1'b1;
			end else begin
				ball_x <= SERVE_LX;
				ball_dx <= 1'b0;
			end
		end else if (state == pong_pkg::PLAY) begin
			if (frame) begin
				if (edge_r) ball_x <= X_MAX;	// park at the edge
				else if (edge_l) ball_x <= '0;
				else if (!ball_dx) ball_x <= ball_x + SPX;
				else ball_x <= ball_x - SPX;

				if (!ball_dy) begin	// moving down
					if (ball_y + SPY >= Y_MAX) begin
						ball_y <= Y_MAX;
						ball_dy <= 1'b1;
					end else begin
						ball_y <= ball_y + SPY;
					end
				end else begin	// moving up
					if (ball_y <= SPY) begin
						ball_y <= '0;
						ball_dy <= 1'b0;
					end else begin
						ball_y <= ball_y - SPY;
					end
				end
			end
			if (hit_l && ball_dx) ball_dx <= 1'b0;	// bounce right
			if (hit_r && !ball_dx) ball_dx <= 1'b1;	// bounce left
		end
	end

	// player paddle on the left and computer paddle on the right
	always_ff @(posedge clk_pix) begin
		if (rst || state == pong_pkg::POSITION) begin
			padl_y <= PAD_MID;
			padr_y <= PAD_MID;
		end else if (frame) begin
			if (dn) begin
				if (padl_y + PSPY >= PAD_MAX) padl_y <= PAD_MAX;	// clamp bottom
				else padl_y <= padl_y + PSPY;
			end else if (up) begin
				if (padl_y <= PSPY) padl_y <= '0;	// clamp top
				else padl_y <= padl_y - PSPY;
			end

			// computer lines up its centre with the ball centre
			if (padr_y + PAD_HALF < ball_y + BALL_HALF) begin
				if (padr_y + PSPY >= PAD_MAX) padr_y <= PAD_MAX;
				else padr_y <= padr_y + PSPY;
			end else if (padr_y + PAD_HALF > ball_y + BALL_HALF) begin
				if (padr_y <= PSPY) padr_y <= '0;
				else padr_y <= padr_y - PSPY;
			end
		end
	end

endmodule

// File: pong_painter.sv
// pixel painter
// object tests per pixel, hit strobes, colour choice and registered video out

module pong_painter #(
	parameter int H_RES = 480,
	parameter int V_RES = 272,
	parameter int BALL_SIZE = 8,
	parameter int PAD_HEIGHT = 48,
	parameter int PAD_WIDTH = 10,
	parameter int PAD_OFFS = 32
) (
	input  logic clk_pix,
	input  logic rst,
	input  pong_pkg::coord_t sx,
	input  pong_pkg::coord_t sy,
	input  logic de,
	input  logic hsync,
	input  logic vsync,
	input  pong_pkg::coord_t ball_x,
	input  pong_pkg::coord_t ball_y,
	input  pong_pkg::coord_t padl_y,
	input  pong_pkg::coord_t padr_y,
	output logic hit_l,	// ball pixel on left paddle
	output logic hit_r,	// ball pixel on right paddle
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_de,
	output pong_pkg::chan_t vga_r,
	output pong_pkg::chan_t vga_g,
	output pong_pkg::chan_t vga_b
);

	localparam pong_pkg::coord_t BALL_W = pong_pkg::coord_t'(BALL_SIZE);
	localparam pong_pkg::coord_t PAD_H = pong_pkg::coord_t'(PAD_HEIGHT);
	localparam pong_pkg::coord_t PADL_X0 = pong_pkg::coord_t'(PAD_OFFS);
	localparam pong_pkg::coord_t PADL_X1 = pong_pkg::coord_t'(PAD_OFFS + PAD_WIDTH);
	localparam pong_pkg::coord_t PADR_X0 = pong_pkg::coord_t'(H_RES - PAD_OFFS - PAD_WIDTH);
	localparam pong_pkg::coord_t PADR_X1 = pong_pkg::coord_t'(H_RES - PAD_OFFS);
	localparam pong_pkg::coord_t MID_X = pong_pkg::coord_t'(H_RES / 2);
	localparam pong_pkg::coord_t H_ACT = pong_pkg::coord_t'(H_RES);
	localparam pong_pkg::coord_t V_ACT = pong_pkg::coord_t'(V_RES);

	logic in_area, ball, padl, padr, mid_line;
	pong_pkg::chan_t paint_r, paint_g, paint_b;

	always_comb begin
		in_area = (sx < H_ACT) && (sy < V_ACT);	// no hits from blanking
		ball = in_area && (sx >= ball_x) && (sx < ball_x + BALL_W)
			&& (sy >= ball_y) && (sy < ball_y + BALL_W);
		padl = in_area && (sx >= PADL_X0) && (sx < PADL_X1)
			&& (sy >= padl_y) && (sy < padl_y + PAD_H);
		padr = in_area && (sx >= PADR_X0) && (sx < PADR_X1)
			&& (sy >= padr_y) && (sy < padr_y + PAD_H);
		mid_line = (sx == MID_X) && (sy[3:2] != 2'b00);	// 12 on and 4 off
		hit_l = ball && padl;
		hit_r = ball && padr;
	end

	always_comb begin
		if (ball) begin
			{paint_r, paint_g, paint_b} =
				{pong_pkg::COL_BALL_R, pong_pkg::COL_BALL_G, pong_pkg::COL_BALL_B};
		end else if (padl || padr || mid_line) begin
			{paint_r, paint_g, paint_b} =
				{pong_pkg::COL_PAD_R, pong_pkg::COL_PAD_G, pong_pkg::COL_PAD_B};
		end else begin
			{paint_r, paint_g, paint_b} =
				{pong_pkg::COL_BG_R, pong_pkg::COL_BG_G, pong_pkg::COL_BG_B};
		end
	end

	// output stage one cycle behind sx and sy
	always_ff @(posedge clk_pix) begin
		if (rst) begin
			vga_hsync <= 1'b1;
			vga_vsync <= 1'b1;
			vga_de <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else begin
			vga_hsync <= hsync;
			vga_vsync <= vsync;
			vga_de <= de;
			vga_r <= de ? paint_r : '0;	// black in blanking
			vga_g <= de ? paint_g : '0;
			vga_b <= de ? paint_b : '0;
		end
	end

endmodule

// File: pong_top.sv
// pong top level
// geometry and rule parameters, timing, buttons, game and painter

module pong_top #(
	parameter int H_RES = 480,
	parameter int V_RES = 272,
	parameter int H_FP = 2,
	parameter int H_SYNC = 41,
	parameter int H_BP = 2,
	parameter int V_FP = 2,
	parameter int V_SYNC = 10,
	parameter int V_BP = 2,
	parameter int BALL_SIZE = 8,
	parameter int BALL_SPX = 2,
	parameter int BALL_SPY = 1,
	parameter int PAD_HEIGHT = 48,
	parameter int PAD_WIDTH = 10,
	parameter int PAD_OFFS = 32,
	parameter int PAD_SPY = 3,
	parameter int WIN = 4,	// at most 15
	parameter int DEB_BITS = 16
) (
	input  logic clk_pix,
	input  logic rst,	// stands in for clock lock
	input  logic btn_fire,
	input  logic btn_up,
	input  logic btn_dn,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_de,
	output pong_pkg::chan_t vga_r,
	output pong_pkg::chan_t vga_g,
	output pong_pkg::chan_t vga_b,
	output pong_pkg::score_t score_l,
	output pong_pkg::score_t score_r
);

	pong_pkg::coord_t sx, sy, ball_x, ball_y, padl_y, padr_y;
	logic hsync, vsync, de, frame;
	logic fire, up, dn, hit_l, hit_r;

	display_timing #(
		.H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
	) i_display_timing (
		.clk_pix, .rst, .sx, .sy, .hsync, .vsync, .de, .frame
	);

	button_debounce #(.DEB_BITS(DEB_BITS)) i_deb_fire (
		.clk_pix, .rst, .in(btn_fire), .level(), .press(fire)	// serve on press
	);
	button_debounce #(.DEB_BITS(DEB_BITS)) i_deb_up (
		.clk_pix, .rst, .in(btn_up), .level(up), .press()
	);
	button_debounce #(.DEB_BITS(DEB_BITS)) i_deb_dn (
		.clk_pix, .rst, .in(btn_dn), .level(dn), .press()
	);

	pong_game #(
		.H_RES(H_RES), .V_RES(V_RES), .BALL_SIZE(BALL_SIZE), .BALL_SPX(BALL_SPX),
		.BALL_SPY(BALL_SPY), .PAD_HEIGHT(PAD_HEIGHT), .PAD_WIDTH(PAD_WIDTH),
		.PAD_OFFS(PAD_OFFS), .PAD_SPY(PAD_SPY), .WIN(WIN)
	) i_pong_game (
		.clk_pix, .rst, .frame, .fire, .up, .dn, .hit_l, .hit_r,
		.ball_x, .ball_y, .padl_y, .padr_y, .score_l, .score_r
	);

	pong_painter #(
		.H_RES(H_RES), .V_RES(V_RES), .BALL_SIZE(BALL_SIZE), .PAD_HEIGHT(PAD_HEIGHT),
		.PAD_WIDTH(PAD_WIDTH), .PAD_OFFS(PAD_OFFS)
	) i_pong_painter (
		.clk_pix, .rst, .sx, .sy, .de, .hsync, .vsync,
		.ball_x, .ball_y, .padl_y, .padr_y, .hit_l, .hit_r,
		.vga_hsync, .vga_vsync, .vga_de, .vga_r, .vga_g, .vga_b
	);

endmodule

// File: pong_props.sv
// concurrent checks on the video outputs and the scores
// bound into the pong top level

module pong_props #(
	parameter int WIN = 4
) (
	input logic clk_pix,
	input logic rst,
	input logic vga_de,
	input pong_pkg::chan_t vga_r,
	input pong_pkg::chan_t vga_g,
	input pong_pkg::chan_t vga_b,
	input pong_pkg::score_t score_l,
	input pong_pkg::score_t score_r
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam pong_pkg::score_t WIN_S = pong_pkg::score_t'(WIN);

	// black outside the active area
	a_blank_black: assert property (@(posedge clk_pix) disable iff (rst)
		!vga_de |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else $error("colour pins not black while vga_de is low");

	a_score_limit: assert property (@(posedge clk_pix) disable iff (rst)
		score_l <= WIN_S && score_r <= WIN_S)
		else $error("a score is above the win limit");

	// one point to one side per step or a clear to zero
	a_score_step: assert property (@(posedge clk_pix) disable iff (rst)
		(score_l != '0 || score_r != '0) |->
			((score_l == $past(score_l) && score_r == $past(score_r))
			|| (score_l == $past(score_l) + 1'b1 && score_r == $past(score_r))
			|| (score_l == $past(score_l) && score_r == $past(score_r) + 1'b1)))
		else $error("scores changed by more than one point in a cycle");

endmodule

bind pong_top pong_props #(.WIN(WIN)) i_pong_props (
	.clk_pix(clk_pix), .rst(rst), .vga_de(vga_de), .vga_r(vga_r), .vga_g(vga_g),
	.vga_b(vga_b), .score_l(score_l), .score_r(score_r)
);

// File: tb_pong.sv
// testbench for the pong top level on a 64x32 screen
// clock, reset, vector reader, frame and pixel tracker, compare tasks, timeout

module tb_pong;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int H_RES = 64;
	localparam int V_RES = 32;
	localparam int H_FP = 2;
	localparam int H_SYNC = 4;
	localparam int H_BP = 2;
	localparam int V_FP = 1;
	localparam int V_SYNC = 2;
	localparam int V_BP = 1;
	localparam int H_TOT = H_RES + H_FP + H_SYNC + H_BP;	// 72 cycles per line
	localparam int V_TOT = V_RES + V_FP + V_SYNC + V_BP;	// 36 lines per frame
	localparam int FRAME_CYC = H_TOT * V_TOT;
	localparam int RST_CYC = 16;
	localparam int MAX_STEPS = 32;

	logic clk_pix = 1'b0;
	logic rst, btn_fire, btn_up, btn_dn;
	logic vga_hsync, vga_vsync, vga_de;
	pong_pkg::chan_t vga_r, vga_g, vga_b;
	pong_pkg::score_t score_l, score_r;

	string st_name [MAX_STEPS];	// vector table
	string st_kind [MAX_STEPS];
	int st_fire [MAX_STEPS], st_up [MAX_STEPS], st_dn [MAX_STEPS], st_frames [MAX_STEPS];
	int st_a [MAX_STEPS], st_b [MAX_STEPS], st_c [MAX_STEPS], st_d [MAX_STEPS];
	int st_e [MAX_STEPS];
	int n_steps = 0;

	int col, row, frames, cyc_frame, cyc_line;	// tracker state
	logic de_prev, vs_prev, hs_prev, seen_vs, seen_hs;
	int samp_col = 0;	// pixel to capture
	int samp_row = 0;
	int samp_req = 0;	// capture handshake
	int samp_ack;
	pong_pkg::chan_t cap_r, cap_g, cap_b;
	int cycles = 0;
	int limit = 0;	// timeout in cycles, 0 until vectors are read
	int seed = 32'hcb30;

	pong_top #(
		.H_RES(H_RES), .V_RES(V_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP), .BALL_SIZE(4), .BALL_SPX(2),
		.BALL_SPY(1), .PAD_HEIGHT(8), .PAD_WIDTH(2), .PAD_OFFS(4), .PAD_SPY(1),
		.WIN(2), .DEB_BITS(2)
	) i_pong_top (
		.clk_pix, .rst, .btn_fire, .btn_up, .btn_dn, .vga_hsync, .vga_vsync, .vga_de,
		.vga_r, .vga_g, .vga_b, .score_l, .score_r
	);

	always #50 clk_pix = ~clk_pix;	// 100 ns period

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_score(input string name, input pong_pkg::score_t exp,
		input pong_pkg::score_t act);
		if (exp !== act) begin
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_colour(input string name,
		input pong_pkg::chan_t exp_r, input pong_pkg::chan_t exp_g,
		input pong_pkg::chan_t exp_b, input pong_pkg::chan_t act_r,
		input pong_pkg::chan_t act_g, input pong_pkg::chan_t act_b);
		if ({exp_r, exp_g, exp_b} !== {act_r, act_g, act_b}) begin
			$display("FAIL %s expected %h %h %h actual %h %h %h", name,
				exp_r, exp_g, exp_b, act_r, act_g, act_b);
			abort_run();
		end
	endtask

	// frame, line and pixel tracking on the registered video outputs
	always @(posedge clk_pix) begin
		if (rst) begin
			col <= 0;
			row <= 0;
			frames <= 0;
			cyc_frame <= 0;
			cyc_line <= 0;
			de_prev <= 1'b0;
			vs_prev <= 1'b1;
			hs_prev <= 1'b1;
			seen_vs <= 1'b0;
			seen_hs <= 1'b0;
			samp_ack <= 0;
		end else begin
			de_prev <= vga_de;
			vs_prev <= vga_vsync;
			hs_prev <= vga_hsync;
			cyc_frame <= cyc_frame + 1;
			cyc_line <= cyc_line + 1;
			if (vga_de) begin
				col <= col + 1;
				if (samp_ack != samp_req && col == samp_col && row == samp_row) begin
					cap_r <= vga_r;	// requested pixel
					cap_g <= vga_g;
					cap_b <= vga_b;
					samp_ack <= samp_req;
				end
			end else if (de_prev) begin	// end of an active run
				check_count("active pixels per line", H_RES, col);
				col <= 0;
				row <= row + 1;
			end
			if (!vga_hsync && hs_prev) begin
				if (seen_hs) check_count("hsync period", H_TOT, cyc_line);
				seen_hs <= 1'b1;
				cyc_line <= 1;
			end
			if (!vga_vsync && vs_prev) begin	// new frame
				check_count("active lines per frame", V_RES, row);
				if (seen_vs) check_count("vsync period", FRAME_CYC, cyc_frame);
				seen_vs <= 1'b1;
				cyc_frame <= 1;
				row <= 0;
				frames <= frames + 1;
			end
		end
	end

	always @(posedge clk_pix) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, the vector steps did not finish", cycles);
			abort_run();
		end
	end

	task automatic read_vectors();
		int fd, code, ch, f, u, d, n, a, b, c, dd, e;
		string word, kind;
		fd = $fopen("pong_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open the vector file pong_vectors.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", word);
			if (code != 1) break;
			if (word.getc(0) == "#") begin
				ch = 0;
				while (ch != 10 && ch != -1) ch = $fgetc(fd);	// skip comment line
			end else begin
				code = $fscanf(fd, "%d %d %d %d %s %d %d %h %h %h",
					f, u, d, n, kind, a, b, c, dd, e);
				if (code != 10 || n_steps >= MAX_STEPS) begin
					$display("vector step %s is incomplete or the table is full", word);
					abort_run();
				end
				st_name[n_steps] = word;
				st_kind[n_steps] = kind;
				st_fire[n_steps] = f;
				st_up[n_steps] = u;
				st_dn[n_steps] = d;
				st_frames[n_steps] = n;
				st_a[n_steps] = a;
				st_b[n_steps] = b;
				st_c[n_steps] = c;
				st_d[n_steps] = dd;
				st_e[n_steps] = e;
				n_steps++;
			end
		end
		$fclose(fd);
	endtask

	task automatic run_step(input int i);
		int target;
		pong_pkg::score_t hi;
		if (st_up[i] != 0 && !btn_up) begin
			target = frames + ($random(seed) & 3);	// random start of an up hold
			while (frames < target) @(negedge clk_pix);
		end
		btn_fire = (st_fire[i] != 0);
		btn_up = (st_up[i] != 0);
		btn_dn = (st_dn[i] != 0);
		target = frames + st_frames[i];
		while (frames < target) @(negedge clk_pix);
		if (st_kind[i] == "s") begin
			hi = (score_l > score_r) ? score_l : score_r;
			check_score({st_name[i], " sum"}, pong_pkg::score_t'(st_a[i]),
				pong_pkg::score_t'(score_l + score_r));
			check_score({st_name[i], " max"}, pong_pkg::score_t'(st_b[i]), hi);
		end else if (st_kind[i] == "c") begin
			samp_col = st_a[i];
			samp_row = st_b[i];
			samp_req = samp_req + 1;	// next frame showing that pixel
			while (samp_ack != samp_req) @(negedge clk_pix);
			check_colour(st_name[i], pong_pkg::chan_t'(st_c[i]), pong_pkg::chan_t'(st_d[i]),
				pong_pkg::chan_t'(st_e[i]), cap_r, cap_g, cap_b);
		end else if (st_kind[i] != "n") begin
			$display("vector step %s has an unknown check kind", st_name[i]);
			abort_run();
		end
	endtask

	initial begin
		int extra;
		rst = 1'b1;
		btn_fire = 1'b0;
		btn_up = 1'b0;
		btn_dn = 1'b0;
		read_vectors();
		extra = 4;
		for (int i = 0; i < n_steps; i++) begin
			extra += st_frames[i];
			if (st_kind[i] == "c") extra += 1;	// capture waits up to a frame
			if (st_up[i] != 0) extra += 3;	// random lead-in
		end
		limit = RST_CYC + 2 + extra * FRAME_CYC;
		repeat (RST_CYC) @(posedge clk_pix);
		@(negedge clk_pix);
		check_count("reset de", 0, int'(vga_de));
		check_count("reset syncs", 3, int'({vga_hsync, vga_vsync}));
		check_colour("reset colour", '0, '0, '0, vga_r, vga_g, vga_b);
		rst = 1'b0;
		for (int i = 0; i < n_steps; i++) run_step(i);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: pong_vectors.txt
# name fire up dn frames kind(s score, c colour, n none) then five values
# s: score sum, higher score | c: column row red green blue in hex | n: unused
serve_ball 0 0 0 0 c 6 14 1f 1c 00
serve_bg 0 0 0 0 c 14 4 02 06 1f
reset_score 0 0 0 1 s 0 0 0 0 0
serve_1 1 0 0 1 n 0 0 0 0 0
rally_1 0 0 0 150 s 1 1 0 0 0
point_hold 0 0 0 4 s 1 1 0 0 0
leave_point 1 0 0 1 n 0 0 0 0 0
release_1 0 0 0 1 n 0 0 0 0 0
serve_2 1 0 0 1 n 0 0 0 0 0
rally_2 0 0 0 150 s 2 2 0 0 0
end_hold 0 0 0 6 s 2 2 0 0 0
restart 1 0 0 1 s 0 0 0 0 0
restart_rel 0 0 0 1 s 0 0 0 0 0
restart_ball 0 0 0 0 c 6 14 1f 1c 00
paddle_up 0 1 0 20 c 4 0 1f 1f 1f
paddle_top 0 1 0 2 c 4 8 02 06 1f

// File: list.f
pong_pkg.sv
display_timing.sv
button_debounce.sv
pong_game.sv
pong_painter.sv
pong_top.sv
pong_props.sv
tb_pong.sv

// File: Makefile
# Verilator build and run for the pong testbench

VERILATOR = verilator
VFLAGS = --binary --assert --timescale 1ns/100ps -j 0
TOP = tb_pong
FLIST = list.f
OBJ_DIR = obj_dir
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
